// ==== project.f ====
+incdir+src
src/etx_pkg.sv
src/etx_reset_seq.sv
src/etx_rsync.sv
src/etx_clk_gen.sv
src/etx_clocks.sv
verification/etx_clocks_tb.sv

// ==== src/etx_clk_gen.sv ====
`timescale 1ns/1ps
`include "etx_defines.svh"

module etx_clk_gen
(
   input  logic                sys_clk,
   input  logic                sys_nreset,
   input  logic                mmcm_reset,
   output logic                mmcm_locked,
   output etx_pkg::etx_txclk_t txclk
);

   localparam int lock_cycles = `ETX_LOCK_CYCLES;
   localparam int lock_cw     = $clog2(lock_cycles);

   logic [lock_cw-1:0] lock_cnt;
   logic               clk_run;
   logic               lclk_q;
   logic [1:0]         div_cnt;
   logic               lclk90_q;
   logic               cclk_en;

   //################################################
   // Lock
   //################################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         lock_cnt    <= '0;
         mmcm_locked <= 1'b0;
      end
      else if (mmcm_reset)
      begin
         lock_cnt    <= '0;
         mmcm_locked <= 1'b0; // Drops on the first edge in reset
      end
      else if (!mmcm_locked)
      begin
         if (lock_cnt == lock_cw'(lock_cycles - 1))
            mmcm_locked <= 1'b1;
         else
            lock_cnt <= lock_cnt + 1'b1;
      end
   end

   assign clk_run = mmcm_locked && !mmcm_reset;

   //################################################
   // Link and core clocks
   //################################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         lclk_q  <= 1'b0;
         div_cnt <= '0;
      end
      else if (!clk_run)
      begin
         lclk_q  <= 1'b0;
         div_cnt <= '0;
      end
      else
      begin
         lclk_q <= !lclk_q;
         if (!lclk_q)
            div_cnt <= div_cnt + 1'b1; // Counts lclk rising edges
      end
   end

   // Falling edge stage for the 90 degree copy and the cclk gate
   always_ff @(negedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         lclk90_q <= 1'b0;
         cclk_en  <= 1'b0;
      end
      else
      begin
         lclk90_q <= lclk_q;
         cclk_en  <= clk_run; // Changes only while sys_clk is low
      end
   end

   assign txclk.lclk      = lclk_q;
   assign txclk.lclk90    = lclk90_q;
   assign txclk.lclk_div4 = div_cnt[1]; // Rises with lclk
   assign txclk.cclk      = sys_clk && cclk_en;

endmodule

// ==== src/etx_clocks.sv ====
`timescale 1ns/1ps

module etx_clocks
(
   input  logic sys_clk,
   input  logic sys_nreset,
   input  logic soft_reset,
   output logic tx_lclk_io,
   output logic tx_lclk90,
   output logic tx_lclk_div4,
   output logic cclk_p,
   output logic cclk_n,
   output logic etx_nreset,
   output logic etx_io_nreset,
   output logic chip_nreset,
   output logic tx_active
);

   etx_pkg::etx_rst_ctrl_t rst_ctrl;
   etx_pkg::etx_txclk_t    txclk;
   logic                   mmcm_locked;

   //################################################
   // Sequencer and clock manager
   //################################################

   etx_reset_seq reset_seq
   (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .soft_reset  (soft_reset),
      .mmcm_locked (mmcm_locked), // Synchronized inside
      .rst_ctrl    (rst_ctrl)
   );

   etx_clk_gen clk_gen
   (
      .sys_clk     (sys_clk),
      .sys_nreset  (sys_nreset),
      .mmcm_reset  (rst_ctrl.mmcm_reset),
      .mmcm_locked (mmcm_locked),
      .txclk       (txclk)
   );

   //################################################
   // Reset synchronizers
   //################################################

   etx_rsync rsync_io
   (
      .clk      (txclk.lclk),
      .nrst_in  (rst_ctrl.tx_nreset),
      .nrst_out (etx_io_nreset)
   );

   etx_rsync rsync_core
   (
      .clk      (txclk.lclk_div4),
      .nrst_in  (rst_ctrl.tx_nreset),
      .nrst_out (etx_nreset)
   );

   assign chip_nreset  = rst_ctrl.chip_nreset;
   assign tx_active    = rst_ctrl.tx_active;
   assign tx_lclk_io   = txclk.lclk;
   assign tx_lclk90    = txclk.lclk90;
   assign tx_lclk_div4 = txclk.lclk_div4;
   assign cclk_p       = txclk.cclk;
   assign cclk_n       = !txclk.cclk; // Differential pair

endmodule

// ==== src/etx_defines.svh ====
`ifndef ETX_DEFINES_SVH
`define ETX_DEFINES_SVH

//################################################
// Sequencer
//################################################

// Heartbeat counter width, one heartbeat every 2**ETX_RCW sys_clk cycles
`define ETX_RCW 4

//################################################
// Clock manager model
//################################################

`define ETX_LOCK_CYCLES 20 // sys_clk cycles from reset release to lock

//################################################
// Reset synchronizers
//################################################

`define ETX_SYNC_DEPTH 2 // Flops per synchronizer

`endif

// ==== src/etx_pkg.sv ====
package etx_pkg;

   // Bring-up sequence states
   typedef enum logic [2:0]
   {
      reset_all      = 3'd0, // Clock manager held in reset
      start_cclk     = 3'd1, // Waiting for first lock
      stop_cclk      = 3'd2,
      deassert_reset = 3'd3, // Chip reset released
      hold_it        = 3'd4, // Waiting for lock again
      active         = 3'd5
   } etx_state_t;

   // Reset and enable controls from the sequencer
   typedef struct packed
   {
      logic mmcm_reset;  // Active high
      logic chip_nreset; // Attached chip reset
      logic tx_nreset;   // Feeds both synchronizers
      logic tx_active;
   } etx_rst_ctrl_t;

   // Clocks from the clock manager
   typedef struct packed
   {
      logic lclk;      // Link clock, half the sys_clk rate
      logic lclk90;    // Link clock shifted by 90 degrees
      logic lclk_div4; // Core clock
      logic cclk;      // Chip clock
   } etx_txclk_t;

endpackage

// ==== src/etx_reset_seq.sv ====
`timescale 1ns/1ps
`include "etx_defines.svh"

module etx_reset_seq
(
   input  logic                   sys_clk,
   input  logic                   sys_nreset,
   input  logic                   soft_reset,
   input  logic                   mmcm_locked,
   output etx_pkg::etx_rst_ctrl_t rst_ctrl
);

   logic [`ETX_RCW-1:0]  hb_cnt;
   logic                 heartbeat;
   logic                 lock_meta;
   logic                 lock_sync;
   etx_pkg::etx_state_t  state;

   //################################################
   // Heartbeat
   //################################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         hb_cnt <= '0;
      else
         hb_cnt <= hb_cnt + 1'b1; // Free running, wraps
   end

   assign heartbeat = &hb_cnt; // One cycle in every 2**ETX_RCW

   //################################################
   // Lock synchronizer
   //################################################

   // Lock comes from the clock manager, asynchronous to sys_clk
   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
      begin
         lock_meta <= 1'b0;
         lock_sync <= 1'b0;
      end
      else
      begin
         lock_meta <= mmcm_locked;
         lock_sync <= lock_meta;
      end
   end

   //################################################
   // Sequence FSM
   //################################################

   always_ff @(posedge sys_clk or negedge sys_nreset)
   begin
      if (!sys_nreset)
         state <= etx_pkg::reset_all;
      else if (heartbeat)
      begin
         case (state)
            etx_pkg::reset_all:
            begin
               if (!soft_reset)
                  state <= etx_pkg::start_cclk;
            end
            etx_pkg::start_cclk:
            begin
               if (lock_sync)
                  state <= etx_pkg::stop_cclk;
            end
            etx_pkg::stop_cclk:
               state <= etx_pkg::deassert_reset;
            etx_pkg::deassert_reset:
               state <= etx_pkg::hold_it;
            etx_pkg::hold_it:
            begin
               if (lock_sync)
                  state <= etx_pkg::active;
            end
            etx_pkg::active:
            begin
               if (soft_reset)
                  state <= etx_pkg::reset_all; // Back to the start
            end
            default:
               state <= etx_pkg::reset_all;
         endcase
      end
   end

   // Controls decoded from the state register only
   always_comb
   begin
      rst_ctrl.mmcm_reset  = (state == etx_pkg::reset_all) ||
                             (state == etx_pkg::stop_cclk) ||
                             (state == etx_pkg::deassert_reset);
      rst_ctrl.chip_nreset = (state == etx_pkg::deassert_reset) ||
                             (state == etx_pkg::hold_it) ||
                             (state == etx_pkg::active);
      rst_ctrl.tx_nreset   = (state == etx_pkg::active);
      rst_ctrl.tx_active   = (state == etx_pkg::active);
   end

endmodule

// ==== src/etx_rsync.sv ====
`timescale 1ns/1ps
`include "etx_defines.svh"

module etx_rsync
(
   input  logic clk,
   input  logic nrst_in,
   output logic nrst_out
);

   localparam int depth = `ETX_SYNC_DEPTH;

   logic [depth-1:0] sync_q;

   // Assert at once, release only after depth edges of clk
   always_ff @(posedge clk or negedge nrst_in)
   begin
      if (!nrst_in)
         sync_q <= '0;
      else
         sync_q <= {sync_q[depth-2:0], 1'b1}; // Shift ones in
   end

   assign nrst_out = sync_q[depth-1];

endmodule

// ==== verification/etx_clocks_tb.sv ====
`timescale 1ns/1ps
`include "etx_defines.svh"

module etx_clocks_tb;

   localparam int period_ns      = 40;
   localparam int half_ns        = period_ns / 2;
   localparam int depth          = `ETX_SYNC_DEPTH;
   localparam int bringup_cycles = 11 * (1 << `ETX_RCW); // Worst case to tx_active
   localparam int num_tests      = 5;
   localparam int watchdog_ns    = 5 * bringup_cycles * num_tests * period_ns;

   logic sys_clk;
   logic sys_nreset;
   logic soft_reset;
   logic tx_lclk_io;
   logic tx_lclk90;
   logic tx_lclk_div4;
   logic cclk_p;
   logic cclk_n;
   logic etx_nreset;
   logic etx_io_nreset;
   logic chip_nreset;
   logic tx_active;

   int          errors;
   int          lclk_rises;
   int          lclk_toggles;
   int          lclk90_rises;
   int          div4_rises;
   int          t_lclk_rise;
   int          t_active_fall;
   int          t_core_fall;
   int          t_io_fall;
   bit          phase_on;
   int unsigned rnd;

   etx_clocks dut0
   (
      .sys_clk       (sys_clk),
      .sys_nreset    (sys_nreset),
      .soft_reset    (soft_reset),
      .tx_lclk_io    (tx_lclk_io),
      .tx_lclk90     (tx_lclk90),
      .tx_lclk_div4  (tx_lclk_div4),
      .cclk_p        (cclk_p),
      .cclk_n        (cclk_n),
      .etx_nreset    (etx_nreset),
      .etx_io_nreset (etx_io_nreset),
      .chip_nreset   (chip_nreset),
      .tx_active     (tx_active)
   );

   initial
   begin
      sys_clk = 1'b0;
      forever #(half_ns) sys_clk = ~sys_clk;
   end

   //################################################
   // Edge monitors
   //################################################

   always @(posedge tx_lclk_io)
   begin
      lclk_rises++;
      t_lclk_rise = int'($time);
   end

   always @(tx_lclk_io) lclk_toggles++;
   always @(posedge tx_lclk_div4) div4_rises++;
   always @(negedge tx_active) t_active_fall = int'($time);
   always @(negedge etx_nreset) t_core_fall = int'($time);
   always @(negedge etx_io_nreset) t_io_fall = int'($time);

   // 90 degree copy trails the link clock by half a sys_clk period
   always @(posedge tx_lclk90)
   begin
      lclk90_rises++;
      if (phase_on)
         check_count("tx_lclk90 delay ns", half_ns, int'($time) - t_lclk_rise);
   end

   //################################################
   // Checks
   //################################################

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns %s expected %b got %b", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input int expected, input int actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic report_error(input string what);
      $display("ERROR at %0t ns: %s", $time, what);
      errors++;
   endtask

   task automatic check_outputs_low();
      check_flag("tx_active", 1'b0, tx_active);
      check_flag("chip_nreset", 1'b0, chip_nreset);
      check_flag("etx_nreset", 1'b0, etx_nreset);
      check_flag("etx_io_nreset", 1'b0, etx_io_nreset);
      check_flag("tx_lclk_io", 1'b0, tx_lclk_io);
      check_flag("cclk_p", 1'b0, cclk_p);
   endtask

   // Waits for tx_active, then for both synchronized resets
   task automatic check_bring_up();
      int cyc;
      int chip_cyc;
      int act_cyc;
      bit io_done;
      bit core_done;
      chip_cyc = -1;
      act_cyc  = -1;
      for (cyc = 1; cyc <= bringup_cycles + 32 && act_cyc < 0; cyc++)
      begin
         @(negedge sys_clk);
         if (chip_nreset === 1'b1 && chip_cyc < 0)
            chip_cyc = cyc;
         if (tx_active === 1'b1)
            act_cyc = cyc;
      end
      if (act_cyc < 0)
         report_error("tx_active never rose");
      else
      begin
         check_flag("chip_nreset before tx_active", 1'b1, chip_cyc >= 0 && chip_cyc < act_cyc);
         lclk_rises = 0;
         div4_rises = 0;
         io_done    = 1'b0;
         core_done  = 1'b0;
         cyc        = 0;
         while (!(io_done && core_done) && cyc < 8 * (depth + 1) + 8)
         begin
            @(negedge sys_clk);
            cyc++;
            if (!io_done && lclk_rises >= depth + 1)
            begin
               check_flag("etx_io_nreset", 1'b1, etx_io_nreset);
               io_done = 1'b1;
            end
            if (!core_done && div4_rises >= depth + 1)
            begin
               check_flag("etx_nreset", 1'b1, etx_nreset);
               core_done = 1'b1;
            end
         end
         if (!(io_done && core_done))
            report_error("link clocks stopped before the reset synchronizers released");
      end
   endtask

   //################################################
   // Tests
   //################################################

   task automatic reset_hold_quiet();
      @(negedge sys_clk);
      repeat (7)
      begin
         @(posedge sys_clk);
         #10 check_outputs_low(); // Away from both clock edges
         @(negedge sys_clk);
      end
      sys_nreset = 1'b1;
      repeat (64)
      begin
         @(posedge sys_clk);
         #10 check_outputs_low();
         @(negedge sys_clk);
      end
   endtask

   task automatic first_bring_up();
      @(negedge sys_clk);
      soft_reset = 1'b0;
      check_bring_up();
   endtask

   task automatic clock_relations();
      @(negedge sys_clk);
      #10;
      lclk_rises   = 0;
      div4_rises   = 0;
      lclk90_rises = 0;
      phase_on     = 1'b1;
      repeat (64)
      begin
         @(posedge sys_clk);
         #10 check_flag("cclk_n", ~cclk_p, cclk_n);
         check_flag("cclk_p", sys_clk, cclk_p);
         @(negedge sys_clk);
         #10 check_flag("cclk_n", ~cclk_p, cclk_n);
         check_flag("cclk_p", sys_clk, cclk_p);
      end
      phase_on = 1'b0;
      check_count("tx_lclk_io rises", 32, lclk_rises);
      check_count("tx_lclk_div4 rises", 8, div4_rises);
      check_count("tx_lclk90 rises", 32, lclk90_rises);
   endtask

   task automatic soft_reset_cycle();
      int cyc;
      int extra;
      extra         = rnd % 32; // Added hold time for soft_reset
      t_active_fall = -1;
      t_core_fall   = -1;
      t_io_fall     = -1;
      @(negedge sys_clk);
      soft_reset = 1'b1;
      cyc = 0;
      while (tx_active !== 1'b0 && cyc < 17)
      begin
         @(negedge sys_clk);
         cyc++;
      end
      if (tx_active !== 1'b0)
         report_error("tx_active did not fall after soft_reset");
      else
      begin
         check_count("etx_nreset fall time", t_active_fall, t_core_fall);
         check_count("etx_io_nreset fall time", t_active_fall, t_io_fall);
      end
      repeat (16) @(negedge sys_clk);
      check_flag("chip_nreset", 1'b0, chip_nreset);
      lclk_toggles = 0;
      repeat (16) @(negedge sys_clk);
      check_count("tx_lclk_io edges", 0, lclk_toggles);
      repeat (extra) @(negedge sys_clk);
      soft_reset = 1'b0;
      check_bring_up();
   endtask

   task automatic sys_reset_midrun();
      @(negedge sys_clk);
      sys_nreset = 1'b0;
      #1;
      check_flag("tx_active", 1'b0, tx_active);
      check_flag("chip_nreset", 1'b0, chip_nreset);
      check_flag("etx_nreset", 1'b0, etx_nreset);
      check_flag("etx_io_nreset", 1'b0, etx_io_nreset);
      repeat (8) @(negedge sys_clk);
      sys_nreset = 1'b1;
      check_bring_up();
   endtask

   initial
   begin
      #(watchdog_ns);
      report_error("watchdog expired before the tests finished");
      $display("errors: %0d", errors);
      $display("tests failed");
      $finish;
   end

   initial
   begin
      errors     = 0;
      phase_on   = 1'b0;
      sys_nreset = 1'b0;
      soft_reset = 1'b1;
      rnd        = $urandom(32'hb0cdcb25);
      reset_hold_quiet();
      first_bring_up();
      clock_relations();
      soft_reset_cycle();
      sys_reset_midrun();
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule
